/* hw/customInstruction_config.svh */
`ifndef CUSTOM_INSTRUCTION_CONFIG_SVH
`define CUSTOM_INSTRUCTION_CONFIG_SVH

`define CI_WORD_WIDTH 32
`define CI_ID_WIDTH 8

`define CI_SWAP_ID 1
`define CI_GRAY_ID 9
`define CI_DELAY_ID 6

`define RESET_COUNT_WIDTH 5
`define CYCLES_PER_MICROSECOND 8

`endif

/* hw/ciPkg.sv */
`include "customInstruction_config.svh"

package ciPkg;

  // One operand or one result of a custom instruction.
  typedef logic [`CI_WORD_WIDTH-1:0] ciWordT;

  // Identifier carried on ciN.
  typedef logic [`CI_ID_WIDTH-1:0] ciIdT;

endpackage

/* hw/resetSequencer.sv */
`timescale 1ns/1ps
`include "customInstruction_config.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset,
  output logic cameraResetN
);

  localparam int TOP_BIT = `RESET_COUNT_WIDTH - 1;

  logic [`RESET_COUNT_WIDTH-1:0] resetCountReg;

  // The counter runs from lock until its top bit sets and then stays there.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCountReg <= '0;
    end else if (!resetCountReg[TOP_BIT]) begin
      resetCountReg <= resetCountReg + 1'b1;
    end
  end

  // Both resets are released on the same edge.
  assign cameraResetN = resetCountReg[TOP_BIT];
  assign cpuReset     = ~resetCountReg[TOP_BIT];

  countNeverBackward : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    resetCountReg >= $past(resetCountReg)
  );

endmodule

/* hw/pixelFormatUnit.sv */
`timescale 1ns/1ps
`include "customInstruction_config.svh"

module pixelFormatUnit (
  input  logic          ciStart,
  input  ciPkg::ciIdT   ciN,
  input  ciPkg::ciWordT ciDataA,
  output logic          pixelDone,
  output ciPkg::ciWordT pixelResult
);

  import ciPkg::*;

  logic        isSwap;
  logic        isGray;
  ciWordT      swappedWord;
  ciWordT      grayWord;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] weightedSum;
  logic [7:0]  grayLevel;

  assign isSwap = ciStart && (ciN == ciIdT'(`CI_SWAP_ID));
  assign isGray = ciStart && (ciN == ciIdT'(`CI_GRAY_ID));

  assign swappedWord = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};

  // The RGB565 fields are widened to 8 bits by padding zeros below.
  assign red   = {ciDataA[15:11], 3'b000};
  assign green = {ciDataA[10:5], 2'b00};
  assign blue  = {ciDataA[4:0], 3'b000};

  // The weights add up to 256, so the sum never exceeds 16 bits.
  assign weightedSum = 16'd77 * red + 16'd150 * green + 16'd29 * blue;
  assign grayLevel   = weightedSum[15:8];
  assign grayWord    = {{(`CI_WORD_WIDTH-8){1'b0}}, grayLevel};

  assign pixelDone = isSwap || isGray;

  always_comb begin
    if (isSwap) begin
      pixelResult = swappedWord;
    end else if (isGray) begin
      pixelResult = grayWord;
    end else begin
      pixelResult = '0;
    end
  end

endmodule

/* hw/microDelayUnit.sv */
`timescale 1ns/1ps
`include "customInstruction_config.svh"

module microDelayUnit #(
  parameter int cyclesPerMicrosecond = `CYCLES_PER_MICROSECOND
) (
  input  logic          s_systemClock,
  input  logic          cpuReset,
  input  logic          ciStart,
  input  ciPkg::ciIdT   ciN,
  input  ciPkg::ciWordT ciDataA,
  output logic          delayDone,
  output ciPkg::ciWordT delayResult
);

  import ciPkg::*;

  localparam int PRESCALE_WIDTH =
    (cyclesPerMicrosecond > 1) ? $clog2(cyclesPerMicrosecond) : 1;
  localparam logic [PRESCALE_WIDTH-1:0] PRESCALE_RELOAD =
    PRESCALE_WIDTH'(cyclesPerMicrosecond - 1);

  logic                      startDelay;
  logic                      delayBusy;
  logic                      lastCycle;
  ciWordT                    microCount;
  logic [PRESCALE_WIDTH-1:0] prescaler;

  assign startDelay = ciStart && (ciN == ciIdT'(`CI_DELAY_ID));

  // The final cycle of the final microsecond.
  assign lastCycle = delayBusy && (microCount == ciWordT'(1)) && (prescaler == '0);

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      delayBusy  <= 1'b0;
      microCount <= '0;
      prescaler  <= '0;
    end else if (startDelay) begin
      delayBusy <= 1'b1;
      // A zero count still takes one cycle.
      if (ciDataA == '0) begin
        microCount <= ciWordT'(1);
        prescaler  <= '0;
      end else begin
        microCount <= ciDataA;
        prescaler  <= PRESCALE_RELOAD;
      end
    end else if (lastCycle) begin
      delayBusy <= 1'b0;
    end else if (delayBusy) begin
      if (prescaler == '0) begin
        prescaler  <= PRESCALE_RELOAD;
        microCount <= microCount - 1'b1;
      end else begin
        prescaler <= prescaler - 1'b1;
      end
    end
  end

  assign delayDone   = lastCycle;
  assign delayResult = '0;

  // The processor blocks on the delay, so it cannot issue a second start.
  noStartWhileBusy : assert property (
    @(posedge s_systemClock) disable iff (cpuReset)
    delayBusy |-> !ciStart
  );

endmodule

/* hw/ciResponseMerge.sv */
`timescale 1ns/1ps

module ciResponseMerge (
  input  logic          s_systemClock,
  input  logic          cpuReset,
  input  logic          pixelDone,
  input  ciPkg::ciWordT pixelResult,
  input  logic          delayDone,
  input  ciPkg::ciWordT delayResult,
  output logic          ciDone,
  output ciPkg::ciWordT ciResult
);

  import ciPkg::*;

  logic   anyDone;
  ciWordT mergedResult;

  assign anyDone = pixelDone | delayDone;

  // Only a unit that reports done may contribute to the result.
  assign mergedResult = anyDone ? (pixelResult | delayResult) : '0;

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= anyDone;
      ciResult <= mergedResult;
    end
  end

  // The OR merge is only valid with one instruction in flight.
  singleResponder : assert property (
    @(posedge s_systemClock) disable iff (cpuReset)
    !(pixelDone && delayDone)
  );

endmodule

/* hw/customInstructionComplex.sv */
`timescale 1ns/1ps

module customInstructionComplex (
  input  logic          s_systemClock,
  input  logic          s_pllLocked,
  input  logic          ciStart,
  input  ciPkg::ciIdT   ciN,
  input  ciPkg::ciWordT ciDataA,
  input  ciPkg::ciWordT ciDataB,
  output logic          ciDone,
  output ciPkg::ciWordT ciResult,
  output logic          cameraResetN
);

  import ciPkg::*;

  logic   cpuReset;
  logic   pixelDone;
  logic   delayDone;
  ciWordT pixelResult;
  ciWordT delayResult;

  resetSequencer resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset),
    .cameraResetN (cameraResetN)
  );

  // Byte swap and gray conversion answer in the start cycle.
  pixelFormatUnit pixelFormat (
    .ciStart    (ciStart),
    .ciN        (ciN),
    .ciDataA    (ciDataA),
    .pixelDone  (pixelDone),
    .pixelResult(pixelResult)
  );

  microDelayUnit delayMicro (
    .s_systemClock(s_systemClock),
    .cpuReset     (cpuReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .delayDone    (delayDone),
    .delayResult  (delayResult)
  );

  // ciDataB stays on the port for the processor. None of these units needs it.
  ciResponseMerge responseMerge (
    .s_systemClock(s_systemClock),
    .cpuReset     (cpuReset),
    .pixelDone    (pixelDone),
    .pixelResult  (pixelResult),
    .delayDone    (delayDone),
    .delayResult  (delayResult),
    .ciDone       (ciDone),
    .ciResult     (ciResult)
  );

endmodule

/* testbench/tbCustomInstruction.sv */
`timescale 1ns/1ps
`include "customInstruction_config.svh"

module tbCustomInstruction;

  import ciPkg::*;

  localparam int CLOCK_PERIOD = 4;
  localparam int RESET_CYCLES = 4;
  localparam int CYCLES_PER_US = `CYCLES_PER_MICROSECOND;
  localparam int RELEASE_CYCLES = 1 << (`RESET_COUNT_WIDTH - 1);
  localparam int DONE_MARGIN = 8;
  localparam int UNKNOWN_WAIT = 100;
  localparam int PIXEL_COST = 1 + DONE_MARGIN + 2;
  localparam int DELAY_COST = CYCLES_PER_US * (0 + 1 + 3 + 10) + 1 + 4 * (1 + DONE_MARGIN + 2);
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 1) + RELEASE_CYCLES + DONE_MARGIN
                                   + 36 * PIXEL_COST + DELAY_COST + UNKNOWN_WAIT + 1 + 50;

  logic   s_systemClock;
  logic   s_pllLocked;
  logic   ciStart;
  ciIdT   ciN;
  ciWordT ciDataA;
  ciWordT ciDataB;
  logic   ciDone;
  ciWordT ciResult;
  logic   cameraResetN;

  logic [31:0] lcgState;
  string       currentTest;
  int          testErrors;
  int          errorCount;
  int          testCount;
  int          failedTests;

  customInstructionComplex dut (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .ciDone       (ciDone),
    .ciResult     (ciResult),
    .cameraResetN (cameraResetN)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(CLOCK_PERIOD / 2) s_systemClock = ~s_systemClock;
  end

  // Ends a run that hangs somewhere in a test.
  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, currentTest);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic ciWordT expectedSwap(input ciWordT word);
    ciWordT swapped;
    swapped = '0;
    for (int i = 0; i < 4; i++) begin
      swapped[8*(3-i) +: 8] = word[8*i +: 8];
    end
    return swapped;
  endfunction

  // RGB565 expanded to 8 bits per channel, then weighted 77/150/29 over 256.
  function automatic ciWordT expectedGray(input ciWordT pixel);
    int red;
    int green;
    int blue;
    int gray;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    gray  = (77 * red + 150 * green + 29 * blue) / 256;
    return ciWordT'(gray);
  endfunction

  task automatic beginTest(input string name);
    currentTest = name;
    testErrors  = 0;
  endtask

  task automatic endTest();
    testCount++;
    if (testErrors == 0) begin
      $display("Test %s passed", currentTest);
    end else begin
      failedTests++;
      $display("Test %s failed with %0d errors", currentTest, testErrors);
    end
  endtask

  task automatic reportFailure(input string message);
    $display("%s: %s at %0t", currentTest, message, $time);
    testErrors++;
    errorCount++;
  endtask

  task automatic checkValue(input string signalName, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got 0x%h, expected 0x%h (%s at %0t)", signalName, actual, expected,
               currentTest, $time);
      testErrors++;
      errorCount++;
    end
  endtask

  // Latency counts rising edges after the start edge until ciDone is seen high.
  task automatic issueAndWait(input ciIdT id, input ciWordT operand, input int limit,
                              output int latency, output ciWordT result);
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= id;
    ciDataA <= operand;
    ciDataB <= nextRandom();
    latency = -1;
    result  = '0;
    // The start cycle itself carries no response yet.
    @(negedge s_systemClock);
    if (ciDone !== 1'b0) begin
      reportFailure("ciDone high in the start cycle");
    end
    checkValue("ciResult", ciResult, '0);
    for (int cycle = 1; cycle <= limit && latency < 0; cycle++) begin
      @(posedge s_systemClock);
      ciStart <= 1'b0;
      @(negedge s_systemClock);
      if (ciDone === 1'b1) begin
        latency = cycle;
        result  = ciResult;
      end else if (ciResult !== '0) begin
        checkValue("ciResult", ciResult, '0);
      end
    end
  endtask

  task automatic checkIdleCycle();
    @(posedge s_systemClock);
    @(negedge s_systemClock);
    if (ciDone !== 1'b0) begin
      reportFailure("ciDone stayed high for more than one cycle");
    end
    checkValue("ciResult", ciResult, '0);
  endtask

  task automatic runInstruction(input ciIdT id, input ciWordT operand, input int expectedLatency,
                                input ciWordT expectedResult);
    int     latency;
    ciWordT result;
    issueAndWait(id, operand, expectedLatency + DONE_MARGIN, latency, result);
    if (latency < 0) begin
      reportFailure($sformatf("no ciDone for operand 0x%h within %0d cycles", operand,
                              expectedLatency + DONE_MARGIN));
    end else begin
      checkValue("ciDone latency", 32'(latency), 32'(expectedLatency));
      checkValue("ciResult", result, expectedResult);
    end
    checkIdleCycle();
  endtask

  task automatic testResetRelease();
    int releaseCycle;
    beginTest("resetRelease");
    releaseCycle = -1;
    repeat (RESET_CYCLES) begin
      @(posedge s_systemClock);
      @(negedge s_systemClock);
      if (cameraResetN !== 1'b0) begin
        reportFailure("cameraResetN high while the PLL is not locked");
      end
      if (ciDone !== 1'b0) begin
        reportFailure("ciDone high while the PLL is not locked");
      end
      checkValue("ciResult", ciResult, '0);
    end
    @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    for (int cycle = 1; cycle <= RELEASE_CYCLES + DONE_MARGIN; cycle++) begin
      @(posedge s_systemClock);
      @(negedge s_systemClock);
      if (ciDone !== 1'b0) begin
        reportFailure("ciDone high during reset sequencing");
      end
      checkValue("ciResult", ciResult, '0);
      if (dut.cpuReset !== ~cameraResetN) begin
        reportFailure("cpuReset and cameraResetN were not released together");
      end
      if (releaseCycle < 0 && cameraResetN === 1'b1) begin
        releaseCycle = cycle;
      end
      if (releaseCycle >= 0 && cameraResetN !== 1'b1) begin
        reportFailure("cameraResetN dropped again after release");
      end
    end
    if (releaseCycle < 0) begin
      reportFailure("cameraResetN was never released");
    end else begin
      checkValue("cameraResetN release cycle", 32'(releaseCycle), 32'(RELEASE_CYCLES));
    end
    endTest();
  endtask

  task automatic testByteSwap();
    ciWordT operand;
    beginTest("byteSwap");
    repeat (20) begin
      operand = nextRandom();
      runInstruction(ciIdT'(`CI_SWAP_ID), operand, 1, expectedSwap(operand));
    end
    endTest();
  endtask

  task automatic testGray();
    ciWordT namedPixels[5];
    ciWordT pixel;
    beginTest("grayConversion");
    // Pure red, pure green, pure blue, white and black.
    namedPixels = '{32'h0000_F800, 32'h0000_07E0, 32'h0000_001F, 32'h0000_FFFF, 32'h0000_0000};
    foreach (namedPixels[i]) begin
      runInstruction(ciIdT'(`CI_GRAY_ID), namedPixels[i], 1, expectedGray(namedPixels[i]));
    end
    repeat (10) begin
      pixel = nextRandom();
      runInstruction(ciIdT'(`CI_GRAY_ID), pixel, 1, expectedGray(pixel));
    end
    endTest();
  endtask

  task automatic testDelay();
    int delayCounts[4];
    int expectedLatency;
    beginTest("microDelay");
    delayCounts = '{0, 1, 3, 10};
    foreach (delayCounts[i]) begin
      expectedLatency = delayCounts[i] * CYCLES_PER_US;
      if (expectedLatency < 1) begin
        expectedLatency = 1;
      end
      expectedLatency = expectedLatency + 1;
      runInstruction(ciIdT'(`CI_DELAY_ID), ciWordT'(delayCounts[i]), expectedLatency, '0);
    end
    endTest();
  endtask

  task automatic testUnknownId();
    int     latency;
    ciWordT result;
    ciWordT operand;
    beginTest("unknownIdentifier");
    issueAndWait(ciIdT'(200), nextRandom(), UNKNOWN_WAIT, latency, result);
    if (latency >= 0) begin
      reportFailure($sformatf("unknown identifier got a ciDone after %0d cycles", latency));
    end
    operand = nextRandom();
    runInstruction(ciIdT'(`CI_SWAP_ID), operand, 1, expectedSwap(operand));
    endTest();
  endtask

  initial begin
    s_pllLocked = 1'b0;
    ciStart     = 1'b0;
    ciN         = '0;
    ciDataA     = '0;
    ciDataB     = '0;
    lcgState    = 32'h90c872c0;
    currentTest = "startup";
    testErrors  = 0;
    errorCount  = 0;
    testCount   = 0;
    failedTests = 0;

    testResetRelease();
    testByteSwap();
    testGray();
    testDelay();
    testUnknownId();

    $display("Summary: %0d tests run, %0d failed, %0d errors", testCount, failedTests,
             errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+hw
hw/ciPkg.sv
hw/resetSequencer.sv
hw/pixelFormatUnit.sv
hw/microDelayUnit.sv
hw/ciResponseMerge.sv
hw/customInstructionComplex.sv
testbench/tbCustomInstruction.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in its output.
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tbCustomInstruction -f src.f -o simCustomInstruction \
  && ./obj_dir/simCustomInstruction | tee /dev/stderr | grep -q "^NO ERRORS$" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
